//--- common/img_pkg.sv
package img_pkg;

    // ==============================
    // Image record layout
    // ==============================
    localparam int HEADER_WORDS    = 4;
    localparam int FRAME_WIDTH     = 8;
    localparam int FRAME_HEIGHT    = 4;
    localparam int PIXEL_WORDS     = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int CHECKSUM_WORDS  = 2;
    localparam int IMG_WORDS       = HEADER_WORDS + PIXEL_WORDS + CHECKSUM_WORDS;

    // ==============================
    // Storage sizes
    // ==============================
    localparam int RAM_BLOCKS      = 2;
    localparam int BLOCK_DEPTH     = 64;
    localparam int FIFO_DEPTH      = 16;
    localparam int RAM_INIT_CYCLES = 20;

    typedef logic [15:0] word_t;
    typedef logic [11:0] pixel_t;
    // Most significant word goes out first
    typedef logic [63:0] header_t;
    typedef logic [17:0] stat_count_t;
    typedef logic [6:0]  word_count_t;
    typedef logic [5:0]  addr_t;
    typedef logic [0:0]  block_t;

    typedef enum logic [1:0] {RAM_NONE, RAM_WRITE, RAM_READ} ram_cmd_t;

    typedef enum logic [2:0] {
        CTRL_IDLE, CTRL_WAIT_INIT, CTRL_START, CTRL_WRITE, CTRL_READ
    } ctrl_state_t;

    typedef enum logic [2:0] {
        FR_IDLE, FR_HEADER, FR_WAIT_LOW, FR_WAIT_HIGH, FR_PIXELS, FR_CHECK_HI
    } framer_state_t;

endpackage

//--- common/word_stream_if.sv
`timescale 1ns/1ns

// Word stream with ready/trigger handshake
interface word_stream_if;
    logic           trigger;
    logic           ready;
    img_pkg::word_t data;
    // Set on the final checksum word
    logic           last;

    modport source (
        output trigger,
        output data,
        output last,
        input  ready
    );

    modport sink (
        input  trigger,
        input  data,
        input  last,
        output ready
    );
endinterface

//--- capture/fletcher_checksum.sv
`timescale 1ns/1ns

module fletcher_checksum (
    input  logic           clk,
    input  logic           readout_rst,
    input  logic           clear,
    input  logic           en,
    input  img_pkg::word_t din,
    output logic [31:0]    sum
);
    logic [15:0] s1, s2;
    logic [16:0] s1_raw, s2_raw;
    logic [15:0] s1_next, s2_next;

    // One subtraction brings each sum back below 65535
    always_comb begin
        s1_raw  = {1'b0, s1} + {1'b0, din};
        s1_next = (s1_raw >= 17'd65535) ? 16'(s1_raw - 17'd65535) : s1_raw[15:0];
        s2_raw  = {1'b0, s2} + {1'b0, s1_next};
        s2_next = (s2_raw >= 17'd65535) ? 16'(s2_raw - 17'd65535) : s2_raw[15:0];
    end

    always_ff @(posedge clk) begin
        if (!readout_rst || clear) begin
            s1 <= '0;
            s2 <= '0;
        end else if (en) begin
            s1 <= s1_next;
            s2 <= s2_next;
        end
    end

    assign sum = {s2, s1};

endmodule

//--- capture/pixel_framer.sv
`timescale 1ns/1ns

module pixel_framer (
    input  logic                 clk,
    input  logic                 readout_rst,
    input  logic                 start,
    input  logic                 flush,
    input  img_pkg::header_t     header,
    input  logic                 img_fv,
    input  logic                 img_lv,
    input  img_pkg::pixel_t      img_d,
    word_stream_if.source        out,
    output img_pkg::word_count_t word_count,
    output img_pkg::stat_count_t highlight_count,
    output img_pkg::stat_count_t shadow_count
);
    img_pkg::framer_state_t state;
    img_pkg::header_t       hdr_shift;
    logic [$clog2(img_pkg::HEADER_WORDS)-1:0] hdr_left;
    logic [1:0]     col, row;
    logic           lv_prev;
    logic           pix_valid, sample;
    logic           emit, emit_check, emit_last;
    img_pkg::word_t emit_word, pixel_word;
    logic [31:0]    sum;

    fletcher_checksum u_checksum (
        .clk         (clk),
        .readout_rst (readout_rst),
        .clear       (start),
        .en          (emit && !emit_check),
        .din         ({emit_word[7:0], emit_word[15:8]}),
        .sum         (sum)
    );

    // Pixels count once the frame start has been seen
    assign pix_valid = img_fv && img_lv &&
                       (state == img_pkg::FR_WAIT_HIGH || state == img_pkg::FR_PIXELS);
    assign sample = pix_valid && col == 2'd0 && row == 2'd0;
    // Little endian pixel word
    assign pixel_word = {img_d[7:0], 4'h0, img_d[11:8]};

    // ==============================
    // Next word to send
    // ==============================
    always_comb begin
        emit       = 1'b0;
        emit_check = 1'b0;
        emit_last  = 1'b0;
        emit_word  = hdr_shift[63:48];
        if (!flush && !start) begin
            case (state)
                img_pkg::FR_HEADER: emit = 1'b1;
                img_pkg::FR_WAIT_HIGH: begin
                    emit      = pix_valid;
                    emit_word = pixel_word;
                end
                img_pkg::FR_PIXELS: begin
                    emit       = pix_valid || !img_fv;
                    emit_check = !img_fv;
                    emit_word  = img_fv ? pixel_word : {sum[7:0], sum[15:8]};
                end
                img_pkg::FR_CHECK_HI: begin
                    emit       = 1'b1;
                    emit_check = 1'b1;
                    emit_last  = 1'b1;
                    emit_word  = {sum[23:16], sum[31:24]};
                end
                default: emit = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state           <= img_pkg::FR_IDLE;
            hdr_left        <= '0;
            col             <= '0;
            row             <= '0;
            lv_prev         <= 1'b0;
            out.trigger     <= 1'b0;
            out.last        <= 1'b0;
            word_count      <= '0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            out.trigger <= emit;
            out.last    <= emit_last;
            lv_prev     <= img_lv;
            col         <= img_lv ? col + 2'd1 : 2'd0;
            if (!img_fv) begin
                row <= 2'd0;
            end else if (lv_prev && !img_lv) begin
                row <= row + 2'd1;
            end

            if (emit) begin
                word_count <= word_count + 1'b1;
            end
            // Top seven bits decide highlight or shadow
            if (sample && img_d[11:5] == 7'h7f) begin
                highlight_count <= highlight_count + 1'b1;
            end
            if (sample && img_d[11:5] == 7'h00) begin
                shadow_count <= shadow_count + 1'b1;
            end

            if (flush) begin
                state <= img_pkg::FR_IDLE;
            end else if (start) begin
                state           <= img_pkg::FR_HEADER;
                hdr_left        <= $bits(hdr_left)'(img_pkg::HEADER_WORDS - 1);
                word_count      <= '0;
                highlight_count <= '0;
                shadow_count    <= '0;
            end else begin
                case (state)
                    img_pkg::FR_HEADER: begin
                        hdr_left <= hdr_left - 1'b1;
                        if (hdr_left == '0) state <= img_pkg::FR_WAIT_LOW;
                    end
                    img_pkg::FR_WAIT_LOW:  if (!img_fv) state <= img_pkg::FR_WAIT_HIGH;
                    img_pkg::FR_WAIT_HIGH: if (img_fv) state <= img_pkg::FR_PIXELS;
                    img_pkg::FR_PIXELS:    if (!img_fv) state <= img_pkg::FR_CHECK_HI;
                    img_pkg::FR_CHECK_HI:  state <= img_pkg::FR_IDLE;
                    default:               state <= img_pkg::FR_IDLE;
                endcase
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        out.data  <= emit_word;
        hdr_shift <= start ? header : (emit ? hdr_shift << 16 : hdr_shift);
    end

endmodule

//--- hw/word_fifo.sv
`timescale 1ns/1ns

module word_fifo (
    input  logic          clk,
    input  logic          readout_rst,
    input  logic          flush,
    word_stream_if.sink   wr,
    word_stream_if.source rd
);
    img_pkg::word_t mem_data [img_pkg::FIFO_DEPTH];
    logic           mem_last [img_pkg::FIFO_DEPTH];
    logic [$clog2(img_pkg::FIFO_DEPTH)-1:0] wr_ptr, rd_ptr;
    logic [$clog2(img_pkg::FIFO_DEPTH):0]   fill;
    logic push, pop;

    // Depth is a power of two so the top fill bit means full
    assign wr.ready   = !fill[$clog2(img_pkg::FIFO_DEPTH)];
    assign rd.trigger = fill != '0;
    assign rd.data    = mem_data[rd_ptr];
    assign rd.last    = mem_last[rd_ptr];
    assign push       = wr.trigger && wr.ready;
    assign pop        = rd.trigger && rd.ready;

    always_ff @(posedge clk) begin
        if (!readout_rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr] <= wr.data;
            mem_last[wr_ptr] <= wr.last;
        end
    end

endmodule

//--- hw/ram_store.sv
`timescale 1ns/1ns

module ram_store (
    input  logic              clk,
    input  logic              readout_rst,
    input  img_pkg::ram_cmd_t cmd,
    input  img_pkg::block_t   cmd_block,
    output logic              init_done,
    word_stream_if.sink       wr,
    output logic              write_end,
    output logic              readout_ready,
    input  logic              readout_trigger,
    output img_pkg::word_t    readout_data,
    output logic              read_end
);
    img_pkg::word_t    mem [img_pkg::RAM_BLOCKS * img_pkg::BLOCK_DEPTH];
    img_pkg::ram_cmd_t mode;
    img_pkg::block_t   block;
    img_pkg::addr_t    wr_addr, rd_addr;
    logic [$clog2(img_pkg::RAM_INIT_CYCLES)-1:0] init_cnt;
    logic store, fetch, consume;

    assign wr.ready = init_done && mode == img_pkg::RAM_WRITE;
    assign store    = wr.trigger && wr.ready;
    // One idle cycle before each word is presented
    assign fetch    = init_done && mode == img_pkg::RAM_READ && !readout_ready;
    assign consume  = readout_ready && readout_trigger;

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            init_cnt      <= '0;
            init_done     <= 1'b0;
            mode          <= img_pkg::RAM_NONE;
            block         <= '0;
            wr_addr       <= '0;
            rd_addr       <= '0;
            readout_ready <= 1'b0;
            write_end     <= 1'b0;
            read_end      <= 1'b0;
        end else begin
            write_end <= 1'b0;
            read_end  <= 1'b0;

            // Stand-in for SDRAM power-up
            if (!init_done) begin
                init_cnt <= init_cnt + 1'b1;
                if (init_cnt == img_pkg::RAM_INIT_CYCLES - 1) init_done <= 1'b1;
            end

            if (cmd != img_pkg::RAM_NONE) begin
                mode          <= cmd;
                block         <= cmd_block;
                wr_addr       <= '0;
                rd_addr       <= '0;
                readout_ready <= 1'b0;
            end else begin
                if (store) begin
                    wr_addr <= wr_addr + 1'b1;
                    if (wr.last) begin
                        write_end <= 1'b1;
                        mode      <= img_pkg::RAM_NONE;
                    end
                end
                if (fetch) readout_ready <= 1'b1;
                if (consume) begin
                    readout_ready <= 1'b0;
                    rd_addr       <= rd_addr + 1'b1;
                    if (rd_addr == img_pkg::addr_t'(img_pkg::IMG_WORDS - 1)) begin
                        read_end <= 1'b1;
                        mode     <= img_pkg::RAM_NONE;
                    end
                end
            end
        end
    end

    // Memory array with registered read
    always_ff @(posedge clk) begin
        if (store) mem[{block, wr_addr}] <= wr.data;
        if (fetch) readout_data <= mem[{block, rd_addr}];
    end

endmodule

//--- hw/capture_control.sv
`timescale 1ns/1ns

module capture_control (
    input  logic              clk,
    input  logic              readout_rst,
    input  logic              cmd_capture,
    input  logic              cmd_readout,
    input  img_pkg::block_t   cmd_ram_block,
    input  logic              init_done,
    input  logic              write_end,
    input  logic              read_end,
    output img_pkg::ram_cmd_t ram_cmd,
    output img_pkg::block_t   ram_block,
    output logic              framer_start,
    output logic              fifo_flush,
    output logic              capture_done,
    output logic              readout_busy
);
    img_pkg::ctrl_state_t state;

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state        <= img_pkg::CTRL_IDLE;
            ram_cmd      <= img_pkg::RAM_NONE;
            ram_block    <= '0;
            framer_start <= 1'b0;
            fifo_flush   <= 1'b0;
            capture_done <= 1'b0;
            readout_busy <= 1'b0;
        end else begin
            // Single-cycle pulses
            ram_cmd      <= img_pkg::RAM_NONE;
            framer_start <= 1'b0;
            fifo_flush   <= 1'b0;
            capture_done <= 1'b0;

            case (state)
                img_pkg::CTRL_IDLE: begin
                    if (cmd_capture) begin
                        ram_cmd   <= img_pkg::RAM_WRITE;
                        ram_block <= cmd_ram_block;
                        state     <= img_pkg::CTRL_WAIT_INIT;
                    end else if (cmd_readout) begin
                        ram_cmd      <= img_pkg::RAM_READ;
                        ram_block    <= cmd_ram_block;
                        readout_busy <= 1'b1;
                        state        <= img_pkg::CTRL_READ;
                    end
                end
                // Store must be up before pixels flow
                img_pkg::CTRL_WAIT_INIT: begin
                    if (init_done) begin
                        fifo_flush <= 1'b1;
                        state      <= img_pkg::CTRL_START;
                    end
                end
                img_pkg::CTRL_START: begin
                    framer_start <= 1'b1;
                    state        <= img_pkg::CTRL_WRITE;
                end
                img_pkg::CTRL_WRITE: begin
                    if (write_end) begin
                        capture_done <= 1'b1;
                        state        <= img_pkg::CTRL_IDLE;
                    end
                end
                img_pkg::CTRL_READ: begin
                    if (read_end) begin
                        readout_busy <= 1'b0;
                        state        <= img_pkg::CTRL_IDLE;
                    end
                end
                default: state <= img_pkg::CTRL_IDLE;
            endcase
        end
    end

endmodule

//--- hw/img_capture_top.sv
`timescale 1ns/1ns

module img_capture_top (
    input  logic                 clk,
    input  logic                 readout_rst,
    input  logic                 cmd_capture,
    input  logic                 cmd_readout,
    input  img_pkg::block_t      cmd_ram_block,
    input  img_pkg::header_t     cmd_header,
    input  logic                 img_fv,
    input  logic                 img_lv,
    input  img_pkg::pixel_t      img_d,
    input  logic                 readout_trigger,
    output logic                 capture_done,
    output logic                 readout_busy,
    output logic                 readout_ready,
    output img_pkg::word_t       readout_data,
    output img_pkg::word_count_t status_word_count,
    output img_pkg::stat_count_t status_highlight_count,
    output img_pkg::stat_count_t status_shadow_count
);
    img_pkg::ram_cmd_t ram_cmd;
    img_pkg::block_t   ram_block;
    logic init_done, write_end, read_end;
    logic framer_start, fifo_flush;

    word_stream_if stream_fill ();
    word_stream_if stream_store ();

    // ==============================
    // Framer, FIFO, store
    // ==============================
    pixel_framer u_framer (
        .clk (clk), .readout_rst (readout_rst),
        .start (framer_start), .flush (fifo_flush), .header (cmd_header),
        .img_fv (img_fv), .img_lv (img_lv), .img_d (img_d),
        .out (stream_fill.source), .word_count (status_word_count),
        .highlight_count (status_highlight_count), .shadow_count (status_shadow_count)
    );

    word_fifo u_fifo (
        .clk (clk), .readout_rst (readout_rst), .flush (fifo_flush),
        .wr (stream_fill.sink), .rd (stream_store.source)
    );

    ram_store u_store (
        .clk (clk), .readout_rst (readout_rst),
        .cmd (ram_cmd), .cmd_block (ram_block), .init_done (init_done),
        .wr (stream_store.sink), .write_end (write_end),
        .readout_ready (readout_ready), .readout_trigger (readout_trigger),
        .readout_data (readout_data), .read_end (read_end)
    );

    // Sequencer beside the pipeline
    capture_control u_control (
        .clk (clk), .readout_rst (readout_rst),
        .cmd_capture (cmd_capture), .cmd_readout (cmd_readout),
        .cmd_ram_block (cmd_ram_block), .init_done (init_done),
        .write_end (write_end), .read_end (read_end),
        .ram_cmd (ram_cmd), .ram_block (ram_block),
        .framer_start (framer_start), .fifo_flush (fifo_flush),
        .capture_done (capture_done), .readout_busy (readout_busy)
    );

endmodule

//--- test/tb_img_capture.sv
`timescale 1ns/1ns

module tb_img_capture;

    localparam int RESET_CYCLES = 4;
    localparam int HBLANK_MAX   = 4;
    localparam int BLANK_SPREAD = 8;
    // Covers RAM init, control latency and header before the first line
    localparam int SETUP_BLANK  = img_pkg::RAM_INIT_CYCLES + 16;
    localparam int FRAME_CYCLES = SETUP_BLANK + BLANK_SPREAD + 10 +
                                  img_pkg::FRAME_HEIGHT * (img_pkg::FRAME_WIDTH + HBLANK_MAX);
    localparam int READ_CYCLES  = 3 * img_pkg::IMG_WORDS + 4;
    localparam int NUM_FRAMES   = 3;
    localparam int NUM_READS    = 4;
    localparam int WATCHDOG_CYCLES =
        4 * (RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES + NUM_READS * READ_CYCLES);

    logic                 clk = 1'b0;
    logic                 readout_rst;
    logic                 cmd_capture;
    logic                 cmd_readout;
    img_pkg::block_t      cmd_ram_block;
    img_pkg::header_t     cmd_header;
    logic                 img_fv;
    logic                 img_lv;
    img_pkg::pixel_t      img_d;
    logic                 readout_trigger;
    logic                 capture_done;
    logic                 readout_busy;
    logic                 readout_ready;
    img_pkg::word_t       readout_data;
    img_pkg::word_count_t status_word_count;
    img_pkg::stat_count_t status_highlight_count;
    img_pkg::stat_count_t status_shadow_count;

    // Reference model state
    img_pkg::pixel_t  pixel_q [$];
    img_pkg::word_t   rec_q [$];
    img_pkg::word_t   model_rec [img_pkg::RAM_BLOCKS][img_pkg::IMG_WORDS];
    int               model_high [img_pkg::RAM_BLOCKS];
    int               model_shadow [img_pkg::RAM_BLOCKS];
    img_pkg::header_t hdr0;
    img_pkg::header_t hdr1;

    img_capture_top uut (
        .clk                    (clk),
        .readout_rst            (readout_rst),
        .cmd_capture            (cmd_capture),
        .cmd_readout            (cmd_readout),
        .cmd_ram_block          (cmd_ram_block),
        .cmd_header             (cmd_header),
        .img_fv                 (img_fv),
        .img_lv                 (img_lv),
        .img_d                  (img_d),
        .readout_trigger        (readout_trigger),
        .capture_done           (capture_done),
        .readout_busy           (readout_busy),
        .readout_ready          (readout_ready),
        .readout_data           (readout_data),
        .status_word_count      (status_word_count),
        .status_highlight_count (status_highlight_count),
        .status_shadow_count    (status_shadow_count)
    );

    always #4 clk = ~clk;

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        assert (got === expected) else begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic img_pkg::word_t swap_bytes(input img_pkg::word_t w);
        return {w[7:0], w[15:8]};
    endfunction

    // About a third of the pixels land on a highlight or shadow value
    function automatic img_pkg::pixel_t random_pixel();
        int unsigned pick;
        pick = $urandom % 6;
        if (pick == 0) begin
            return {7'h7f, 5'($urandom)};
        end else if (pick == 1) begin
            return {7'h00, 5'($urandom)};
        end
        return 12'($urandom);
    endfunction

    // ==============================
    // Reference model
    // ==============================
    function automatic void build_record(input img_pkg::header_t hdr, input int blk);
        int unsigned     s1;
        int unsigned     s2;
        int              i;
        img_pkg::pixel_t p;
        rec_q.delete();
        s1 = 0;
        s2 = 0;
        model_high[blk] = 0;
        model_shadow[blk] = 0;
        for (i = 0; i < img_pkg::HEADER_WORDS; i++) begin
            rec_q.push_back(hdr[63 - 16 * i -: 16]);
        end
        for (i = 0; i < pixel_q.size(); i++) begin
            p = pixel_q[i];
            rec_q.push_back({p[7:0], 4'h0, p[11:8]});
            // Grid of every fourth row and column
            if ((i / img_pkg::FRAME_WIDTH) % 4 == 0 && (i % img_pkg::FRAME_WIDTH) % 4 == 0) begin
                if (p[11:5] == 7'h7f) model_high[blk]++;
                if (p[11:5] == 7'h00) model_shadow[blk]++;
            end
        end
        for (i = 0; i < rec_q.size(); i++) begin
            s1 = (s1 + swap_bytes(rec_q[i])) % 65535;
            s2 = (s2 + s1) % 65535;
        end
        rec_q.push_back(swap_bytes(s1[15:0]));
        rec_q.push_back(swap_bytes(s2[15:0]));
        for (i = 0; i < img_pkg::IMG_WORDS; i++) begin
            model_rec[blk][i] = rec_q[i];
        end
    endfunction

    task automatic pulse_capture(input int blk, input img_pkg::header_t hdr);
        cmd_ram_block = 1'(blk);
        cmd_header    = hdr;
        cmd_capture   = 1'b1;
        @(negedge clk);
        cmd_capture = 1'b0;
    endtask

    // Camera frame with an optional capture pulse at the start of one line
    task automatic drive_frame(input int lead_blank, input int capture_line);
        int row;
        int col;
        img_pkg::pixel_t p;
        pixel_q.delete();
        img_fv = 1'b0;
        img_lv = 1'b0;
        repeat (lead_blank) @(negedge clk);
        img_fv = 1'b1;
        @(negedge clk);
        for (row = 0; row < img_pkg::FRAME_HEIGHT; row++) begin
            if (row == capture_line) cmd_capture = 1'b1;
            for (col = 0; col < img_pkg::FRAME_WIDTH; col++) begin
                p = random_pixel();
                pixel_q.push_back(p);
                img_lv = 1'b1;
                img_d  = p;
                @(negedge clk);
                cmd_capture = 1'b0;
            end
            img_lv = 1'b0;
            img_d  = 12'($urandom);
            repeat (1 + $urandom % HBLANK_MAX) @(negedge clk);
        end
        img_fv = 1'b0;
    endtask

    task automatic finish_capture(input int blk, input img_pkg::header_t hdr);
        while (!capture_done) begin
            @(negedge clk);
        end
        build_record(hdr, blk);
        check_equal(status_word_count, img_pkg::IMG_WORDS, "status word count");
        check_equal(status_highlight_count, model_high[blk], "highlight count");
        check_equal(status_shadow_count, model_shadow[blk], "shadow count");
    endtask

    // Consumer with random back-pressure
    task automatic read_block(input int blk);
        int             got;
        logic           trig;
        logic           held;
        img_pkg::word_t held_data;
        cmd_ram_block = 1'(blk);
        cmd_readout   = 1'b1;
        @(negedge clk);
        cmd_readout = 1'b0;
        got       = 0;
        held      = 1'b0;
        held_data = '0;
        while (got < img_pkg::IMG_WORDS) begin
            check_equal(readout_busy, 1, "readout_busy before the last word");
            if (held) begin
                check_equal(readout_ready, 1, "readout_ready while stalled");
                check_equal(readout_data, held_data, "readout_data while stalled");
            end
            trig            = ($urandom % 3) != 0;
            readout_trigger = trig;
            held            = readout_ready && !trig;
            held_data       = readout_data;
            if (readout_ready && trig) begin
                check_equal(readout_data, model_rec[blk][got],
                            $sformatf("block %0d %s %0d", blk,
                                      (got >= img_pkg::IMG_WORDS - 2) ? "checksum word" : "word",
                                      got));
                got++;
            end
            @(negedge clk);
        end
        readout_trigger = 1'b0;
        while (readout_busy) begin
            check_equal(readout_ready, 0, "readout_ready after the last word");
            @(negedge clk);
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        void'($urandom(56));
        readout_rst     = 1'b0;
        cmd_capture     = 1'b0;
        cmd_readout     = 1'b0;
        cmd_ram_block   = '0;
        cmd_header      = '0;
        img_fv          = 1'b0;
        img_lv          = 1'b0;
        img_d           = '0;
        readout_trigger = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        readout_rst = 1'b1;
        check_equal(capture_done, 0, "capture_done after reset");
        check_equal(readout_busy, 0, "readout_busy after reset");
        check_equal(readout_ready, 0, "readout_ready after reset");
        check_equal(status_word_count, 0, "word count after reset");
        check_equal(status_highlight_count, 0, "highlight count after reset");
        check_equal(status_shadow_count, 0, "shadow count after reset");

        // Block 0 commanded while the store is still starting up
        hdr0 = {$urandom, $urandom};
        pulse_capture(0, hdr0);
        drive_frame(SETUP_BLANK + int'($urandom % BLANK_SPREAD), -1);
        finish_capture(0, hdr0);
        read_block(0);

        // Block 1 commanded mid-frame so that the next frame is recorded
        hdr1 = {$urandom, $urandom};
        if (hdr1 == hdr0) hdr1 = ~hdr0;
        cmd_ram_block = 1'b1;
        cmd_header    = hdr1;
        drive_frame(4 + int'($urandom % BLANK_SPREAD), 1);
        drive_frame(4 + int'($urandom % BLANK_SPREAD), -1);
        finish_capture(1, hdr1);
        read_block(1);

        // Both blocks again to catch one overwriting the other
        read_block(0);
        read_block(1);

        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- img_capture.f
common/img_pkg.sv
common/word_stream_if.sv
capture/fletcher_checksum.sv
capture/pixel_framer.sv
hw/word_fifo.sv
hw/ram_store.sv
hw/capture_control.sv
hw/img_capture_top.sv
test/tb_img_capture.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the img_capture testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    -f img_capture.f --top-module tb_img_capture \
    -Mdir obj_dir -o sim_img_capture
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_img_capture
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation returned status $status"
    exit "$status"
fi
exit 0
